// ==== src/icache_pkg.sv ====
// ####################################################################
// icache_pkg
// shared geometry, field types, request struct and FSM state type
// for the two-way set-associative instruction cache
// ####################################################################

package icache_pkg;

    // address split: tag | index | byte offset
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;

    // cache geometry
    localparam int NUM_SETS       = 1 << INDEX_W;
    localparam int NUM_WAYS       = 2;
    localparam int WORDS_PER_LINE = 4;

    // word and line widths
    localparam int WORD_W = 32;
    localparam int LINE_W = WORDS_PER_LINE * WORD_W;

    // bits of the offset that pick a word within the line
    localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);

    // one tag as held in the tag RAM
    typedef logic [TAG_W-1:0] tag_t;

    // set index, also the RAM address
    typedef logic [INDEX_W-1:0] index_t;

    // one instruction word
    typedef logic [WORD_W-1:0] word_t;

    // full line, word k sits at bits 32k upward
    typedef logic [LINE_W-1:0] line_t;

    // one bit per way
    // hit vector, victim and write masks all use it
    typedef logic [NUM_WAYS-1:0] way_t;

    // CPU request as seen on the port and in the request buffer
    typedef struct packed {
        tag_t                tag;
        index_t              index;
        logic [OFFSET_W-1:0] offset;
    } cpu_req_t;

    // controller FSM
    // IDLE    waits for a request
    // LOOKUP  RAM data is back, tag compare happens here
    // MISS    refill request held until rd_rdy
    // REFILL  waits for the returned line
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LOOKUP = 2'd1,
        MISS   = 2'd2,
        REFILL = 2'd3
    } ctrl_state_t;

endpackage

// ==== src/icache_sram.sv ====
// ####################################################################
// icache_sram
// synchronous single-port RAM, one entry per set, registered read,
// entry type given as a type parameter (tags or data words)
// ####################################################################

`timescale 1ns/1ps

module icache_sram #(
    parameter type entry_t = icache_pkg::word_t
) (
    input  logic               clk,
    input  logic               wen,
    input  icache_pkg::index_t addr,
    input  entry_t             wdata,
    output entry_t             rdata
);

    // storage array, one entry per set
    // contents are undefined until the first fill
    entry_t mem [icache_pkg::NUM_SETS];

    // write port
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
        end
    end

    // read port, data shows up one cycle after addr
    // on a same-address write the old entry comes out
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

// ==== src/icache_set_state.sv ====
// ####################################################################
// icache_set_state
// per-set valid bits and LRU bit, gives hit qualification and the
// one-hot victim way for the set currently being looked up
// ####################################################################

`timescale 1ns/1ps

module icache_set_state (
    input  logic               clk,
    input  logic               resetn,
    input  icache_pkg::index_t rd_index,
    input  icache_pkg::index_t upd_index,
    input  logic               hit_upd,
    input  icache_pkg::way_t   hit_way,
    input  logic               fill_upd,
    input  icache_pkg::way_t   fill_way,
    output icache_pkg::way_t   valid_bits,
    output icache_pkg::way_t   victim
);

    // valid bits, one vector per set
    icache_pkg::way_t [icache_pkg::NUM_SETS-1:0] valid_q;

    // lru bit per set, value is the least recently used way
    logic [icache_pkg::NUM_SETS-1:0] lru_q;

    // index delayed to line up with RAM read data
    icache_pkg::index_t rd_index_q;

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            rd_index_q <= '0;
        end else begin
            rd_index_q <= rd_index;
        end
    end

    // state update
    // the used way becomes most recent, so the other one is lru
    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else if (fill_upd) begin
            valid_q[upd_index] <= valid_q[upd_index] | fill_way;
            lru_q[upd_index]   <= fill_way[0];
        end else if (hit_upd) begin
            lru_q[upd_index] <= hit_way[0];
        end
    end

    assign valid_bits = valid_q[rd_index_q];

    // empty way first, otherwise the lru one
    always_comb begin
        victim = '0;
        if (!valid_bits[0]) begin
            victim[0] = 1'b1;
        end else if (!valid_bits[1]) begin
            victim[1] = 1'b1;
        end else begin
            victim[lru_q[rd_index_q]] = 1'b1;
        end
    end

endmodule

// ==== src/icache_ctrl.sv ====
// ####################################################################
// icache_ctrl
// lookup / miss / refill FSM with request buffer, tag compare,
// word select and the single-beat refill request
// ####################################################################

`timescale 1ns/1ps

module icache_ctrl (
    input  logic                      clk,
    input  logic                      resetn,
    // CPU side
    input  logic                      valid,
    input  icache_pkg::cpu_req_t      req,
    output logic                      addr_ok,
    output logic                      data_ok,
    output icache_pkg::word_t         rdata,
    // RAM read data and set state
    input  icache_pkg::tag_t  [icache_pkg::NUM_WAYS-1:0]       way_tag,
    input  icache_pkg::word_t [icache_pkg::NUM_WAYS-1:0]
                              [icache_pkg::WORDS_PER_LINE-1:0] way_word,
    input  icache_pkg::way_t          valid_bits,
    input  icache_pkg::way_t          victim,
    // RAM and set state control
    output icache_pkg::index_t        ram_index,
    output icache_pkg::index_t        upd_index,
    output logic                      hit_upd,
    output icache_pkg::way_t          hit_way,
    output logic                      fill_upd,
    output icache_pkg::way_t          fill_way,
    output icache_pkg::way_t          tag_wen,
    output icache_pkg::way_t          data_wen,
    output icache_pkg::tag_t          fill_tag,
    // refill side
    output logic                      rd_req,
    output logic [31:0]               rd_addr,
    input  logic                      rd_rdy,
    input  logic                      ret_valid,
    input  icache_pkg::line_t         ret_data
);

    icache_pkg::ctrl_state_t state;
    icache_pkg::ctrl_state_t next_state;

    // buffered request, valid from LOOKUP on
    icache_pkg::cpu_req_t req_q;

    // way chosen for the refill, taken when the lookup fails
    icache_pkg::way_t victim_q;

    logic                                hit;
    logic                                accept;
    logic                                fill;
    logic [icache_pkg::WORD_SEL_W-1:0]   word_sel;
    icache_pkg::word_t                   hit_word;
    icache_pkg::word_t                   ret_word;

    // tag compare
    // stale tags of empty ways are masked by the valid bits
    always_comb begin
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            hit_way[w] = valid_bits[w] && (way_tag[w] == req_q.tag);
        end
    end

    // only meaningful in LOOKUP
    assign hit = (state == icache_pkg::LOOKUP) && (|hit_way);

    // ready in IDLE, and in LOOKUP while hitting
    // this is what gives one hit per cycle
    assign addr_ok = (state == icache_pkg::IDLE) || hit;
    assign accept  = valid && addr_ok;

    // the line comes back this cycle
    assign fill = (state == icache_pkg::REFILL) && ret_valid;

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            state <= icache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::IDLE: begin
                if (valid) begin
                    next_state = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::LOOKUP: begin
                if (hit) begin
                    // stay here if another request follows
                    next_state = valid ? icache_pkg::LOOKUP : icache_pkg::IDLE;
                end else if (rd_rdy) begin
                    // refill request already taken
                    next_state = icache_pkg::REFILL;
                end else begin
                    next_state = icache_pkg::MISS;
                end
            end
            icache_pkg::MISS: begin
                if (rd_rdy) begin
                    next_state = icache_pkg::REFILL;
                end
            end
            icache_pkg::REFILL: begin
                if (ret_valid) begin
                    next_state = icache_pkg::IDLE;
                end
            end
            default: begin
                next_state = icache_pkg::IDLE;
            end
        endcase
    end

    // request buffer, loads on every accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // latch victim in the failing lookup cycle
    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            victim_q <= '0;
        end else if ((state == icache_pkg::LOOKUP) && !hit) begin
            victim_q <= victim;
        end
    end

    // RAM address
    // new request index normally, buffered index while refilling
    assign ram_index = ((state == icache_pkg::MISS) || (state == icache_pkg::REFILL))
                       ? req_q.index : req.index;

    // refill request
    // raised in the failing lookup cycle, held until rd_rdy
    assign rd_req  = ((state == icache_pkg::LOOKUP) && !hit) || (state == icache_pkg::MISS);
    assign rd_addr = {req_q.tag, req_q.index, {icache_pkg::OFFSET_W{1'b0}}};

    // line write into the victim way
    assign tag_wen  = fill ? victim_q : '0;
    assign data_wen = fill ? victim_q : '0;
    assign fill_tag = req_q.tag;

    // set state updates, both address the buffered set
    assign upd_index = req_q.index;
    assign hit_upd   = hit;
    assign fill_upd  = fill;
    assign fill_way  = victim_q;

    // word within the line, offset bits 3:2
    assign word_sel = req_q.offset[icache_pkg::OFFSET_W-1 -: icache_pkg::WORD_SEL_W];

    // hit data, one-hot OR over the ways
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            if (hit_way[w]) begin
                hit_word = hit_word | way_word[w][word_sel];
            end
        end
    end

    // miss data comes straight off the return beat
    assign ret_word = ret_data[icache_pkg::WORD_W*word_sel +: icache_pkg::WORD_W];

    assign data_ok = hit || fill;
    assign rdata   = (state == icache_pkg::REFILL) ? ret_word : hit_word;

endmodule

// ==== src/icache_top.sv ====
// ####################################################################
// icache_top
// two-way instruction cache: controller, set state, two tag RAMs
// and four word-wide data banks per way
// ####################################################################

`timescale 1ns/1ps

module icache_top (
    input  logic                 clk,
    input  logic                 resetn,
    // CPU side
    input  logic                 valid,
    input  icache_pkg::cpu_req_t req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output icache_pkg::word_t    rdata,
    // refill side
    output logic                 rd_req,
    output logic [31:0]          rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  icache_pkg::line_t    ret_data
);

    // RAM read data
    icache_pkg::tag_t  [icache_pkg::NUM_WAYS-1:0] way_tag;
    icache_pkg::word_t [icache_pkg::NUM_WAYS-1:0]
                       [icache_pkg::WORDS_PER_LINE-1:0] way_word;

    // set state
    icache_pkg::way_t   valid_bits;
    icache_pkg::way_t   victim;
    icache_pkg::index_t upd_index;
    logic               hit_upd;
    icache_pkg::way_t   hit_way;
    logic               fill_upd;
    icache_pkg::way_t   fill_way;

    // RAM control
    icache_pkg::index_t ram_index;
    icache_pkg::way_t   tag_wen;
    icache_pkg::way_t   data_wen;
    icache_pkg::tag_t   fill_tag;

    icache_ctrl i_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .valid      (valid),
        .req        (req),
        .way_tag    (way_tag),
        .way_word   (way_word),
        .valid_bits (valid_bits),
        .victim     (victim),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_data   (ret_data),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .ram_index  (ram_index),
        .upd_index  (upd_index),
        .hit_upd    (hit_upd),
        .hit_way    (hit_way),
        .fill_upd   (fill_upd),
        .fill_way   (fill_way),
        .tag_wen    (tag_wen),
        .data_wen   (data_wen),
        .fill_tag   (fill_tag),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr)
    );

    // read index follows the RAM address so both line up
    icache_set_state i_set_state (
        .clk        (clk),
        .resetn     (resetn),
        .rd_index   (ram_index),
        .upd_index  (upd_index),
        .hit_upd    (hit_upd),
        .hit_way    (hit_way),
        .fill_upd   (fill_upd),
        .fill_way   (fill_way),
        .valid_bits (valid_bits),
        .victim     (victim)
    );

    for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
        // tag array of this way
        icache_sram #(.entry_t(icache_pkg::tag_t)) i_tag_ram (
            .clk   (clk),
            .wen   (tag_wen[w]),
            .addr  (ram_index),
            .wdata (fill_tag),
            .rdata (way_tag[w])
        );

        // one bank per word, all written together on a fill
        for (genvar k = 0; k < icache_pkg::WORDS_PER_LINE; k++) begin : g_bank
            icache_sram #(.entry_t(icache_pkg::word_t)) i_data_ram (
                .clk   (clk),
                .wen   (data_wen[w]),
                .addr  (ram_index),
                .wdata (ret_data[icache_pkg::WORD_W*k +: icache_pkg::WORD_W]),
                .rdata (way_word[w][k])
            );
        end
    end

endmodule

// ==== verif/icache_assert.sv ====
// ####################################################################
// icache_assert
// protocol assertions for the cache controller
// refill request hold, no data or acceptance while a refill is open
// ####################################################################

`timescale 1ns/1ps

module icache_assert (
    input logic                    clk,
    input logic                    resetn,
    input icache_pkg::ctrl_state_t state,
    input logic                    addr_ok,
    input logic                    data_ok,
    input logic                    rd_req,
    input logic                    rd_rdy,
    input logic [31:0]             rd_addr
);

    // failed assertions so far
    int fail_count = 0;

    // refill request held with a stable address until taken
    a_rd_req_hold: assert property (@(posedge clk) disable iff (resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else begin
            $error("rd_req dropped or rd_addr moved before rd_rdy");
            fail_count++;
        end

    // no result while the line request is still pending
    a_no_data_in_miss: assert property (@(posedge clk) disable iff (resetn)
        state == icache_pkg::MISS |-> !data_ok)
        else begin
            $error("data_ok seen in MISS");
            fail_count++;
        end

    // nothing accepted until the refill is done
    a_no_accept_in_refill: assert property (@(posedge clk) disable iff (resetn)
        (state == icache_pkg::MISS || state == icache_pkg::REFILL) |-> !addr_ok)
        else begin
            $error("addr_ok high during a refill");
            fail_count++;
        end

    // first cycle out of reset
    a_rd_req_reset: assert property (@(posedge clk) $fell(resetn) |-> !rd_req)
        else begin
            $error("rd_req high right after reset");
            fail_count++;
        end

endmodule

bind icache_ctrl icache_assert i_assert (
    .clk     (clk),
    .resetn  (resetn),
    .state   (state),
    .addr_ok (addr_ok),
    .data_ok (data_ok),
    .rd_req  (rd_req),
    .rd_rdy  (rd_rdy),
    .rd_addr (rd_addr)
);

// ==== verif/icache_tb.sv ====
// ####################################################################
// icache_tb
// drives CPU fetches into the two-way instruction cache, serves line
// refills, checks data and refill counts against a reference model
// ####################################################################

`timescale 1ns/1ps

module icache_tb;

    localparam int TIMEOUT = 200;

    logic                 clk;
    logic                 resetn;
    logic                 valid;
    icache_pkg::cpu_req_t req;
    logic                 addr_ok;
    logic                 data_ok;
    icache_pkg::word_t    rdata;
    logic                 rd_req;
    logic [31:0]          rd_addr;
    logic                 rd_rdy;
    logic                 ret_valid;
    icache_pkg::line_t    ret_data;

    integer seed;
    int     cycle;
    int     errors;
    int     refills;
    int     model_misses;
    int     tests_run;
    int     tests_failed;
    string  cur_test;
    int     t_err;
    int     t_fills;
    int     t_miss;

    // reference tag store
    // lru holds the least recently used way
    icache_pkg::tag_t m_tag [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
    logic             m_valid [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
    logic             m_lru [icache_pkg::NUM_SETS];

    // fetch sequence of the current test
    logic [31:0] seq_q [$];

    // accepted requests still waiting for data_ok
    logic [31:0] pend_addr [$];
    bit          pend_hit [$];
    int          pend_cyc [$];

    // refill responder state
    int          rdy_wait;
    int          ret_wait;
    bit          busy;
    logic [31:0] fill_addr;

    icache_top i_dut (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // memory word at byte address a holds a ^ 5a5a0000
    function automatic icache_pkg::word_t mem_word(logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic icache_pkg::line_t make_line(logic [31:0] base);
        icache_pkg::line_t line;
        for (int k = 0; k < icache_pkg::WORDS_PER_LINE; k++) begin
            line[32*k +: 32] = mem_word({base[31:4], 4'h0} + 32'(4 * k));
        end
        return line;
    endfunction

    // hit prediction plus model update
    // invalid way first, else lru way
    function automatic bit model_access(logic [31:0] addr);
        icache_pkg::cpu_req_t r;
        int                   way;
        r = addr;
        way = -1;
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            if (m_valid[r.index][w] && m_tag[r.index][w] == r.tag) begin
                way = w;
            end
        end
        model_access = (way >= 0);
        if (way < 0) begin
            if (!m_valid[r.index][0]) begin
                way = 0;
            end else if (!m_valid[r.index][1]) begin
                way = 1;
            end else begin
                way = m_lru[r.index];
            end
            m_valid[r.index][way] = 1'b1;
            m_tag[r.index][way] = r.tag;
        end
        m_lru[r.index] = (way == 0);
    endfunction

    task automatic model_clear();
        for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_lru[s] = 1'b0;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s: %s", cur_test, why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        resetn <= 1'b1;
        valid  <= 1'b0;
        repeat (10) @(posedge clk);
        resetn <= 1'b0;
        model_clear();
    endtask

    // refill responder
    // random rd_rdy delay 0..5, return latency 1..8
    always @(posedge clk) begin
        if (resetn) begin
            rd_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            busy = 1'b0;
            rdy_wait = -1;
        end else begin
            ret_valid <= 1'b0;
            if (rd_req && rd_rdy) begin
                refills++;
                fill_addr = rd_addr;
                rd_rdy <= 1'b0;
                busy = 1'b1;
                ret_wait = 1 + ($unsigned($random(seed)) % 8);
                if (pend_addr.size() == 0 || rd_addr !== {pend_addr[0][31:4], 4'h0}) begin
                    $display("[FAIL] %s: rd_addr expected line of %h, got %h",
                             cur_test, pend_addr.size() ? pend_addr[0] : 32'h0, rd_addr);
                    errors++;
                end
            end else if (busy) begin
                if (ret_wait == 0) begin
                    ret_valid <= 1'b1;
                    ret_data  <= make_line(fill_addr);
                    busy = 1'b0;
                end
                ret_wait--;
            end else if (rd_req) begin
                if (rdy_wait < 0) begin
                    rdy_wait = $unsigned($random(seed)) % 6;
                end
                if (rdy_wait == 0) begin
                    rd_rdy <= 1'b1;
                end
                rdy_wait--;
            end
        end
    end

    // result checker
    // hits must come one cycle after acceptance
    always @(posedge clk) begin
        if (!resetn && data_ok) begin
            if (pend_addr.size() == 0) begin
                $display("%s: data_ok with no request outstanding", cur_test);
                errors++;
            end else begin
                if (rdata !== mem_word(pend_addr[0])) begin
                    $display("[FAIL] %s: rdata at %h expected %h, got %h", cur_test,
                             pend_addr[0], mem_word(pend_addr[0]), rdata);
                    errors++;
                end
                if (pend_hit[0] && cycle != pend_cyc[0] + 1) begin
                    $display("[FAIL] %s: hit latency expected 1, got %0d", cur_test,
                             cycle - pend_cyc[0]);
                    errors++;
                end
                void'(pend_addr.pop_front());
                void'(pend_hit.pop_front());
                void'(pend_cyc.pop_front());
            end
        end
    end

    // fetch seq_q with valid held high, then drain results
    task automatic run_seq();
        int i;
        int wait_cnt;
        bit last_hit;
        bit hit;
        i = 0;
        wait_cnt = 0;
        last_hit = 1'b0;
        @(posedge clk);
        valid <= 1'b1;
        req   <= seq_q[0];
        while (i < seq_q.size()) begin
            @(posedge clk);
            if (valid && addr_ok) begin
                if (last_hit && wait_cnt != 0) begin
                    $display("%s: addr_ok dropped after a hit", cur_test);
                    errors++;
                end
                hit = model_access(seq_q[i]);
                if (!hit) begin
                    model_misses++;
                end
                pend_addr.push_back(seq_q[i]);
                pend_hit.push_back(hit);
                pend_cyc.push_back(cycle);
                last_hit = hit;
                wait_cnt = 0;
                i++;
                if (i < seq_q.size()) begin
                    req <= seq_q[i];
                end else begin
                    valid <= 1'b0;
                end
            end else begin
                wait_cnt++;
                if (wait_cnt > TIMEOUT) begin
                    abort_run("no addr_ok within the timeout");
                end
            end
        end
        wait_cnt = 0;
        while (pend_addr.size() != 0) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                abort_run("no data_ok within the timeout");
            end
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        t_err = errors;
        t_fills = refills;
        t_miss = model_misses;
    endtask

    // refill count must match the predicted misses
    task automatic finish_test();
        if (refills - t_fills != model_misses - t_miss) begin
            $display("[FAIL] %s: refills expected %0d, got %0d", cur_test,
                     model_misses - t_miss, refills - t_fills);
            errors++;
        end
        tests_run++;
        if (errors != t_err) begin
            tests_failed++;
            $display("%s: failed", cur_test);
        end else begin
            $display("%s: passed, %0d refills", cur_test, refills - t_fills);
        end
    endtask

    initial begin
        icache_pkg::cpu_req_t r;
        clk = 1'b0;
        resetn = 1'b1;
        valid = 1'b0;
        req = '0;
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_data = '0;
        seed = 32'haa78c293;
        cycle = 0;
        errors = 0;
        refills = 0;
        model_misses = 0;
        tests_run = 0;
        tests_failed = 0;
        cur_test = "reset";
        apply_reset();

        start_test("cold_miss");
        seq_q = '{32'h0001_2344};
        run_seq();
        finish_test();

        // remaining offsets of the same line one at a time
        start_test("hit_after_fill");
        seq_q = '{32'h0001_2340};
        run_seq();
        seq_q = '{32'h0001_2348};
        run_seq();
        seq_q = '{32'h0001_234c};
        run_seq();
        finish_test();

        start_test("back_to_back_hits");
        seq_q = '{32'h0001_2340, 32'h0001_2344, 32'h0001_2348, 32'h0001_234c,
                  32'h0001_2340, 32'h0001_2344};
        run_seq();
        finish_test();

        // second tag on index 34
        start_test("two_ways");
        seq_q = '{32'h0004_5340, 32'h0001_2344, 32'h0004_5348};
        run_seq();
        finish_test();

        // A B A C, then A hits and B misses
        start_test("lru_replace");
        seq_q = '{32'h1000_0770, 32'h2000_0770, 32'h1000_0774, 32'h3000_0770,
                  32'h1000_0778, 32'h2000_077c};
        run_seq();
        finish_test();

        // four tags over four sets keep both ways busy
        start_test("random_refill");
        seq_q = {};
        for (int n = 0; n < 48; n++) begin
            r.tag = 20'h00abc + 20'($unsigned($random(seed)) % 4);
            r.index = 8'h80 + 8'($unsigned($random(seed)) % 4);
            r.offset = {2'($unsigned($random(seed)) % 4), 2'b00};
            seq_q.push_back(r);
        end
        run_seq();
        apply_reset();
        // lines cached before the reset must miss now
        seq_q = '{32'h0001_2344, 32'h0004_5340};
        run_seq();
        finish_test();

        // failed protocol assertions count as errors too
        errors += i_dut.i_ctrl.i_assert.fail_count;

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== icache_top.f ====
src/icache_pkg.sv
src/icache_sram.sv
src/icache_set_state.sv
src/icache_ctrl.sv
src/icache_top.sv
verif/icache_assert.sv
verif/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  # cache RTL, package first
  - files:
      - src/icache_pkg.sv
      - src/icache_sram.sv
      - src/icache_set_state.sv
      - src/icache_ctrl.sv
      - src/icache_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - verif/icache_assert.sv
      - verif/icache_tb.sv
